// File: design/mem_port_stage.sv
`default_nettype none
`timescale 1ns/1ps

`include "mem_req_settings.svh"

module mem_port_stage (
  input logic clk,
  input logic reset,
  req_channel_if.port_side rd_chan,
  req_channel_if.port_side wr_chan,
  input logic req_rd_available,
  input logic req_wr_available,
  output logic req_rd_en,
  output logic [`MEM_ADDR_W-1:0] req_rd_addr,
  output logic [`MEM_MDATA_W-1:0] req_rd_mdata,
  output logic req_wr_en,
  output logic [`MEM_ADDR_W-1:0] req_wr_addr,
  output logic [`MEM_MDATA_W-1:0] req_wr_mdata,
  output logic [`MEM_WDATA_W-1:0] req_wr_data,
  output logic [63:0] info
);

  localparam int qid_w = 2; // Tag bits reserved for the queue index

  logic [15:0] rd_issued;
  logic [15:0] wr_issued;

  assign rd_chan.available = req_rd_available;
  assign wr_chan.available = req_wr_available;

  assign info = {16'd0, wr_issued, rd_issued, 8'(`MEM_WR_QUEUES), 8'(`MEM_RD_QUEUES)};

  always_ff @(posedge clk) begin
    if (reset) begin
      req_rd_en <= 1'b0;
      req_wr_en <= 1'b0;
      rd_issued <= '0;
      wr_issued <= '0;
    end else begin
      req_rd_en <= rd_chan.en;
      req_wr_en <= wr_chan.en;
      if (rd_chan.en) begin
        rd_issued <= rd_issued + 1'b1;
      end
      if (wr_chan.en) begin
        wr_issued <= wr_issued + 1'b1;
      end
    end
  end

  // The winning queue index is stamped into the top of the tag
  always_ff @(posedge clk) begin
    if (rd_chan.en) begin
      req_rd_addr <= rd_chan.req.addr;
      req_rd_mdata <= {qid_w'(rd_chan.queue_id), rd_chan.req.mdata[`MEM_MDATA_W-qid_w-1:0]};
    end
    if (wr_chan.en) begin
      req_wr_addr <= wr_chan.req.addr;
      req_wr_data <= wr_chan.req.data;
      req_wr_mdata <= {qid_w'(wr_chan.queue_id), wr_chan.req.mdata[`MEM_MDATA_W-qid_w-1:0]};
    end
  end

endmodule

`default_nettype wire

// File: design/mem_req_manager.sv
`default_nettype none
`timescale 1ns/1ps

`include "mem_req_settings.svh"

module mem_req_manager (
  input logic clk,
  input logic reset,
  input logic [`MEM_RD_QUEUES-1:0] rd_req_en,
  input logic [`MEM_ADDR_W-1:0] rd_req_addr [`MEM_RD_QUEUES],
  input logic [`MEM_MDATA_W-1:0] rd_req_mdata [`MEM_RD_QUEUES],
  output logic [`MEM_RD_QUEUES-1:0] rd_req_available,
  input logic [`MEM_WR_QUEUES-1:0] wr_req_en,
  input logic [`MEM_ADDR_W-1:0] wr_req_addr [`MEM_WR_QUEUES],
  input logic [`MEM_MDATA_W-1:0] wr_req_mdata [`MEM_WR_QUEUES],
  input logic [`MEM_WDATA_W-1:0] wr_req_data [`MEM_WR_QUEUES],
  output logic [`MEM_WR_QUEUES-1:0] wr_req_available,
  output logic req_rd_en,
  output logic [`MEM_ADDR_W-1:0] req_rd_addr,
  output logic [`MEM_MDATA_W-1:0] req_rd_mdata,
  input logic req_rd_available,
  output logic req_wr_en,
  output logic [`MEM_ADDR_W-1:0] req_wr_addr,
  output logic [`MEM_MDATA_W-1:0] req_wr_mdata,
  output logic [`MEM_WDATA_W-1:0] req_wr_data,
  input logic req_wr_available,
  output logic [63:0] info
);

  import mem_req_pkg::*;

  rd_req_t rd_queue_req [`MEM_RD_QUEUES];
  wr_req_t wr_queue_req [`MEM_WR_QUEUES];

  for (genvar q = 0; q < `MEM_RD_QUEUES; q++) begin : g_rd_pack
    assign rd_queue_req[q] = '{addr: rd_req_addr[q], mdata: rd_req_mdata[q]};
  end

  for (genvar q = 0; q < `MEM_WR_QUEUES; q++) begin : g_wr_pack
    assign wr_queue_req[q] = '{data: wr_req_data[q], addr: wr_req_addr[q],
                               mdata: wr_req_mdata[q]};
  end

  req_channel_if #(.req_t(rd_req_t), .num_queues(`MEM_RD_QUEUES)) rd_chan ();
  req_channel_if #(.req_t(wr_req_t), .num_queues(`MEM_WR_QUEUES)) wr_chan ();

  req_arbiter #(
    .req_t(rd_req_t),
    .num_queues(`MEM_RD_QUEUES)
  ) rd_arbiter (
    .clk(clk),
    .reset(reset),
    .queue_en(rd_req_en),
    .queue_req(rd_queue_req),
    .queue_available(rd_req_available),
    .chan(rd_chan.arb_side)
  );

  req_arbiter #(
    .req_t(wr_req_t),
    .num_queues(`MEM_WR_QUEUES)
  ) wr_arbiter (
    .clk(clk),
    .reset(reset),
    .queue_en(wr_req_en),
    .queue_req(wr_queue_req),
    .queue_available(wr_req_available),
    .chan(wr_chan.arb_side)
  );

  mem_port_stage port_stage (
    .clk(clk),
    .reset(reset),
    .rd_chan(rd_chan.port_side),
    .wr_chan(wr_chan.port_side),
    .req_rd_available(req_rd_available),
    .req_wr_available(req_wr_available),
    .req_rd_en(req_rd_en),
    .req_rd_addr(req_rd_addr),
    .req_rd_mdata(req_rd_mdata),
    .req_wr_en(req_wr_en),
    .req_wr_addr(req_wr_addr),
    .req_wr_mdata(req_wr_mdata),
    .req_wr_data(req_wr_data),
    .info(info)
  );

endmodule

`default_nettype wire

// File: design/mem_req_pkg.sv
`default_nettype none

`include "mem_req_settings.svh"

package mem_req_pkg;

  // One read request as it leaves a read queue
  typedef struct packed {
    logic [`MEM_ADDR_W-1:0] addr;
    logic [`MEM_MDATA_W-1:0] mdata; // Top two bits name the queue
  } rd_req_t;

  // One write request as it leaves a write queue
  typedef struct packed {
    logic [`MEM_WDATA_W-1:0] data;
    logic [`MEM_ADDR_W-1:0] addr;
    logic [`MEM_MDATA_W-1:0] mdata;
  } wr_req_t;

endpackage

`default_nettype wire

// File: design/mem_req_settings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// Memory port field widths
`define MEM_ADDR_W 48
`define MEM_MDATA_W 16
`define MEM_WDATA_W 64

// Accelerator request queues
`define MEM_RD_QUEUES 2
`define MEM_WR_QUEUES 3

// Every queue FIFO holds 2**MEM_FIFO_DEPTH_BITS entries
`define MEM_FIFO_DEPTH_BITS 4

`endif

// File: design/req_arbiter.sv
`default_nettype none
`timescale 1ns/1ps

module req_arbiter #(
  parameter type req_t = logic,
  parameter int num_queues = 2
) (
  input logic clk,
  input logic reset,
  input logic [num_queues-1:0] queue_en,
  input req_t queue_req [num_queues],
  output logic [num_queues-1:0] queue_available,
  req_channel_if.arb_side chan
);

  localparam int id_w = $clog2(num_queues);

  req_t head [num_queues];
  logic [num_queues-1:0] fifo_empty;
  logic [num_queues-1:0] fifo_pop;
  logic [id_w-1:0] last_q; // Winner of the previous grant
  logic [id_w-1:0] pick;
  logic found;
  logic grant;

  for (genvar q = 0; q < num_queues; q++) begin : g_queue
    req_fifo #(
      .req_t(req_t)
    ) i_fifo (
      .clk(clk),
      .reset(reset),
      .push(queue_en[q]),
      .push_req(queue_req[q]),
      .pop(fifo_pop[q]),
      .pop_req(head[q]),
      .empty(fifo_empty[q]),
      .room(queue_available[q])
    );

    assign fifo_pop[q] = grant && (pick == q);
  end

  // Search starts at the queue after the last winner and wraps around
  always_comb begin
    int cand;
    found = 1'b0;
    pick = last_q;
    for (int i = 1; i <= num_queues; i++) begin
      cand = (int'(last_q) + i) % num_queues;
      if (!found && !fifo_empty[cand]) begin
        found = 1'b1;
        pick = id_w'(cand);
      end
    end
  end

  assign grant = chan.available && found; // Nothing leaves while the port is full

  always_ff @(posedge clk) begin
    if (reset) begin
      chan.en <= 1'b0;
      last_q <= id_w'(num_queues - 1); // Queue 0 goes first after reset
    end else begin
      chan.en <= grant;
      if (grant) begin
        last_q <= pick;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (grant) begin
      chan.req <= head[pick];
      chan.queue_id <= pick;
    end
  end

endmodule

`default_nettype wire

// File: design/req_channel_if.sv
`default_nettype none
`timescale 1ns/1ps

interface req_channel_if #(
  parameter type req_t = logic,
  parameter int num_queues = 2
);

  logic en; // One cycle per issued request
  req_t req;
  logic [$clog2(num_queues)-1:0] queue_id;
  logic available; // Level from the memory port

  modport arb_side (
    output en,
    output req,
    output queue_id,
    input available
  );

  modport port_side (
    input en,
    input req,
    input queue_id,
    output available
  );

endinterface

`default_nettype wire

// File: design/req_fifo.sv
`default_nettype none
`timescale 1ns/1ps

`include "mem_req_settings.svh"

module req_fifo #(
  parameter type req_t = logic,
  parameter int depth_bits = `MEM_FIFO_DEPTH_BITS
) (
  input logic clk,
  input logic reset,
  input logic push,
  input req_t push_req,
  input logic pop,
  output req_t pop_req,
  output logic empty,
  output logic room
);

  localparam logic [depth_bits:0] depth = {1'b1, {depth_bits{1'b0}}};
  localparam logic [depth_bits:0] room_limit = depth - 2'd2;

  req_t mem [depth];
  logic [depth_bits-1:0] wr_ptr;
  logic [depth_bits-1:0] rd_ptr;
  logic [depth_bits:0] count;
  logic do_push;
  logic do_pop;

  assign do_push = push && (count != depth); // A push into a full FIFO is dropped
  assign do_pop = pop && (count != '0);

  assign empty = (count == '0);
  assign room = (count <= room_limit); // Two free entries cover a request in flight
  assign pop_req = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_req;
    end
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+design
design/mem_req_pkg.sv
design/req_channel_if.sv
design/req_fifo.sv
design/req_arbiter.sv
design/mem_port_stage.sv
design/mem_req_manager.sv
testbench/tb_clock_gen.sv
testbench/tb_mem_req_manager.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the memory-request manager testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_mem_req_manager \
  -f filelist.f \
  --Mdir build \
  -o sim_tb_mem_req_manager

./build/sim_tb_mem_req_manager

// File: testbench/tb_clock_gen.sv
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk; // 4 ns period
  end

  initial begin
    reset <= 1'b1;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

// File: testbench/tb_mem_req_manager.sv
`default_nettype none
`timescale 1ns/1ps

`include "mem_req_settings.svh"

module tb_mem_req_manager;

  import mem_req_pkg::*;

  localparam int seq_w = `MEM_MDATA_W - 2;
  localparam int wait_limit = 2000;

  logic clk;
  logic reset;
  logic [`MEM_RD_QUEUES-1:0] rd_req_en = '0;
  logic [`MEM_ADDR_W-1:0] rd_req_addr [`MEM_RD_QUEUES] = '{default: '0};
  logic [`MEM_MDATA_W-1:0] rd_req_mdata [`MEM_RD_QUEUES] = '{default: '0};
  logic [`MEM_RD_QUEUES-1:0] rd_req_available;
  logic [`MEM_WR_QUEUES-1:0] wr_req_en = '0;
  logic [`MEM_ADDR_W-1:0] wr_req_addr [`MEM_WR_QUEUES] = '{default: '0};
  logic [`MEM_MDATA_W-1:0] wr_req_mdata [`MEM_WR_QUEUES] = '{default: '0};
  logic [`MEM_WDATA_W-1:0] wr_req_data [`MEM_WR_QUEUES] = '{default: '0};
  logic [`MEM_WR_QUEUES-1:0] wr_req_available;
  logic req_rd_en;
  logic [`MEM_ADDR_W-1:0] req_rd_addr;
  logic [`MEM_MDATA_W-1:0] req_rd_mdata;
  logic req_rd_available = 1'b1;
  logic req_wr_en;
  logic [`MEM_ADDR_W-1:0] req_wr_addr;
  logic [`MEM_MDATA_W-1:0] req_wr_mdata;
  logic [`MEM_WDATA_W-1:0] req_wr_data;
  logic req_wr_available = 1'b1;
  logic [63:0] info;

  rd_req_t exp_rd [`MEM_RD_QUEUES][$];
  wr_req_t exp_wr [`MEM_WR_QUEUES][$];
  int rd_seq [`MEM_RD_QUEUES] = '{default: 0};
  int wr_seq [`MEM_WR_QUEUES] = '{default: 0};
  int rd_seen = 0;
  int wr_seen = 0;
  int rd_mode = 0; // 0 idle, 1 random, 2 every cycle
  int wr_mode = 0;
  int rd_avail_mode = 1; // 0 low, 1 high, 2 random
  int wr_avail_mode = 1;
  logic fair_mode = 1'b0;
  int fair_prev [2] = '{default: 0};
  int fair_count = 0;

  tb_clock_gen i_clock_gen (.clk(clk), .reset(reset));

  mem_req_manager i_mem_req_manager (.*);

  task automatic stop_run();
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped after an error");
  endtask

  task automatic report_error(input string msg);
    $display("FAIL %0t ns: %s", $time, msg);
    stop_run();
  endtask

  task automatic timeout_expired(input string what);
    $display("Timeout while waiting for %s after %0d cycles", what, wait_limit);
    stop_run();
  endtask

  function automatic bit wants_request(input int mode);
    return (mode == 2) || (mode == 1 && $urandom_range(0, 1) == 1);
  endfunction

  function automatic logic port_level(input int mode);
    return (mode == 1) || (mode == 2 && $urandom_range(0, 3) != 0);
  endfunction

  function automatic bit queues_empty();
    bit empty;
    empty = 1'b1;
    for (int q = 0; q < `MEM_RD_QUEUES; q++) begin
      if (exp_rd[q].size() != 0) empty = 1'b0;
    end
    for (int q = 0; q < `MEM_WR_QUEUES; q++) begin
      if (exp_wr[q].size() != 0) empty = 1'b0;
    end
    return empty;
  endfunction

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > wait_limit) timeout_expired("the end of reset");
    end while (reset);
  endtask

  task automatic wait_drained(input string what);
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > wait_limit) timeout_expired(what);
    end while (!queues_empty());
  endtask

  // Queues only offer while their own available level is high
  always @(posedge clk) begin
    rd_req_t new_rd;
    wr_req_t new_wr;
    if (!reset) begin
      for (int q = 0; q < `MEM_RD_QUEUES; q++) begin
        if (rd_req_available[q] && wants_request(rd_mode)) begin
          new_rd.addr = `MEM_ADDR_W'({$urandom, $urandom});
          new_rd.mdata = {2'(q), seq_w'(rd_seq[q])}; // Queue index on top
          rd_seq[q]++;
          exp_rd[q].push_back(new_rd);
          rd_req_en[q] <= 1'b1;
          rd_req_addr[q] <= new_rd.addr;
          rd_req_mdata[q] <= new_rd.mdata;
        end else begin
          rd_req_en[q] <= 1'b0;
        end
      end
      for (int q = 0; q < `MEM_WR_QUEUES; q++) begin
        if (wr_req_available[q] && wants_request(wr_mode)) begin
          new_wr.data = {$urandom, $urandom};
          new_wr.addr = `MEM_ADDR_W'({$urandom, $urandom});
          new_wr.mdata = {2'(q), seq_w'(wr_seq[q])};
          wr_seq[q]++;
          exp_wr[q].push_back(new_wr);
          wr_req_en[q] <= 1'b1;
          wr_req_data[q] <= new_wr.data;
          wr_req_addr[q] <= new_wr.addr;
          wr_req_mdata[q] <= new_wr.mdata;
        end else begin
          wr_req_en[q] <= 1'b0;
        end
      end
      req_rd_available <= port_level(rd_avail_mode);
      req_wr_available <= port_level(wr_avail_mode);
    end
  end

  // Scoreboards, issue counters and write fairness
  always @(posedge clk) begin
    int rd_q;
    int wr_q;
    if (!reset) begin
      if (req_rd_en) begin
        rd_q = int'(req_rd_mdata[`MEM_MDATA_W-1 -: 2]);
        assert (rd_q < `MEM_RD_QUEUES && exp_rd[rd_q].size() > 0)
          else report_error("read issued for a queue with nothing outstanding");
        assert (req_rd_addr == exp_rd[rd_q][0].addr && req_rd_mdata == exp_rd[rd_q][0].mdata)
          else report_error($sformatf("read q%0d got %h/%h expected %h", rd_q,
                                      req_rd_addr, req_rd_mdata, exp_rd[rd_q][0]));
        void'(exp_rd[rd_q].pop_front());
        rd_seen++;
      end
      if (req_wr_en) begin
        wr_q = int'(req_wr_mdata[`MEM_MDATA_W-1 -: 2]);
        assert (wr_q < `MEM_WR_QUEUES && exp_wr[wr_q].size() > 0)
          else report_error("write issued for a queue with nothing outstanding");
        assert (req_wr_data == exp_wr[wr_q][0].data && req_wr_addr == exp_wr[wr_q][0].addr &&
                req_wr_mdata == exp_wr[wr_q][0].mdata)
          else report_error($sformatf("write q%0d got %h/%h/%h expected %h", wr_q,
                                      req_wr_data, req_wr_addr, req_wr_mdata, exp_wr[wr_q][0]));
        void'(exp_wr[wr_q].pop_front());
        wr_seen++;
        if (fair_mode) begin
          assert (fair_count < 2 || (wr_q != fair_prev[0] && wr_q != fair_prev[1]))
            else report_error($sformatf("write q%0d repeats within three issues", wr_q));
          fair_prev[1] = fair_prev[0];
          fair_prev[0] = wr_q;
          fair_count++;
        end
      end
      if (!fair_mode) fair_count = 0;
      assert (info[31:16] == 16'(rd_seen) && info[47:32] == 16'(wr_seen))
        else report_error($sformatf("info counts %0d/%0d, observed %0d/%0d",
                                    info[31:16], info[47:32], rd_seen, wr_seen));
    end
  end

  // A port grant needs available high the cycle before the channel edge
  rd_hold: assert property (@(posedge clk) disable iff (reset)
                            req_rd_en |-> $past(req_rd_available, 2))
    else report_error("read issued while the read port was full");
  wr_hold: assert property (@(posedge clk) disable iff (reset)
                            req_wr_en |-> $past(req_wr_available, 2))
    else report_error("write issued while the write port was full");

  initial begin
    void'($urandom(41162));
    wait_reset_release();
    assert (!req_rd_en && !req_wr_en && &rd_req_available && &wr_req_available)
      else report_error("strobes or available levels wrong after reset");
    assert (info[63:16] == '0 && info[7:0] == 8'd2 && info[15:8] == 8'd3)
      else report_error($sformatf("info after reset is %h", info));
    rd_mode <= 1;
    wr_mode <= 1;
    rd_avail_mode <= 2;
    wr_avail_mode <= 2;
    repeat (400) @(posedge clk);
    rd_avail_mode <= 0; // Both ports full, queues fill up
    wr_avail_mode <= 0;
    repeat (40) @(posedge clk);
    rd_mode <= 0;
    wr_mode <= 0;
    rd_avail_mode <= 1;
    wr_avail_mode <= 1;
    wait_drained("the drain after back-pressure");
    wr_avail_mode <= 0; // Fill every write queue before the fairness window
    wr_mode <= 2;
    repeat (24) @(posedge clk);
    wr_avail_mode <= 1;
    repeat (6) @(posedge clk);
    fair_mode <= 1'b1;
    repeat (60) @(posedge clk);
    fair_mode <= 1'b0;
    @(posedge clk);
    wr_mode <= 0;
    wait_drained("the drain after the fairness run");
    repeat (8) @(posedge clk); // A late duplicate would hit an empty expected queue
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire
